// File: src/periph_pkg.sv
// widths, address fields and status codes for the APB peripheral block
// the address map assumes a 20-bit APB address with LWEX/SWEX flags on top
`default_nettype none

package periph_pkg;

    // bus and field widths
    localparam int DATA_WIDTH     = 16;
    localparam int APB_ADDR_WIDTH = 20;
    localparam int CORE_ID_BITS   = 2;
    localparam int SLAVE_BITS     = 4;

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [CORE_ID_BITS-1:0]   core_id_t;
    typedef logic [SLAVE_BITS-1:0]     slave_id_t;

    // upper address bits carry the exclusive access request
    //   19 = LWEX, 18 = SWEX, 17:16 = issuing core
    localparam int ADDR_LWEX_BIT  = 19;
    localparam int ADDR_SWEX_BIT  = 18;
    localparam int ADDR_CORE_LSB  = 16;

    // slave field sits in bits 15:12
    localparam int ADDR_SLAVE_LSB = 12;

    localparam slave_id_t SLAVE_TIMER = slave_id_t'(0);
    localparam slave_id_t SLAVE_SHMEM = slave_id_t'(1);

    // status returned on the read data bus for a SWEX
    localparam data_t SWEX_SUCCESS = data_t'(0);
    localparam data_t SWEX_FAIL    = data_t'(1);

endpackage

`default_nettype wire

// File: src/apb_slave_decode.sv
// APB address decoder for the timer and shared memory slaves
// unmapped slave fields complete in the first access cycle with zero data
`default_nettype none

module apb_slave_decode import periph_pkg::*; (
    input  wire apb_addr_t paddr,
    input  wire            psel,
    input  wire            penable,
    output logic           timer_sel,
    output logic           shmem_sel,
    input  wire data_t     timer_rdata,
    input  wire            timer_ready,
    input  wire data_t     shmem_rdata,
    input  wire            shmem_ready,
    output data_t          prdata,
    output logic           pready
);

    slave_id_t slave_field;
    logic      unmapped_sel;

    assign slave_field = paddr[ADDR_SLAVE_LSB +: SLAVE_BITS];

    // one select per slave, qualified by the master select
    assign timer_sel    = psel && (slave_field == SLAVE_TIMER);
    assign shmem_sel    = psel && (slave_field == SLAVE_SHMEM);
    assign unmapped_sel = psel && !timer_sel && !shmem_sel;

    // slaves drive zero data outside their access cycle,
    // so only the selected one is steered back
    always_comb begin
        prdata = '0;
        pready = 1'b0;
        if (timer_sel) begin
            prdata = timer_rdata;
            pready = timer_ready;
        end else if (shmem_sel) begin
            prdata = shmem_rdata;
            pready = shmem_ready;
        end else if (unmapped_sel) begin
            // nobody home, finish the transfer here
            pready = penable;
        end
    end

endmodule

`default_nettype wire

// File: src/apb_timer.sv
// countdown timer on APB, register select by paddr bit 0
// no wait states; the counter does not step in a cycle with a timer write
`default_nettype none

module apb_timer import periph_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire apb_addr_t paddr,
    input  wire            pwrite,
    input  wire            sel,
    input  wire            penable,
    input  wire data_t     pwdata,
    output data_t          rdata,
    output logic           ready,
    output logic           irq
);

    // register map
    localparam logic ADDR_LOAD = 1'b0;
    localparam logic ADDR_CTRL = 1'b1;

    // control bits
    localparam int CTRL_START  = 0;
    localparam int CTRL_RELOAD = 1;

    logic       access;
    logic       write_en;
    data_t      load_q;
    data_t      count_q;
    logic [1:0] ctrl_q;

    assign access   = sel && penable;
    assign write_en = access && pwrite;
    assign ready    = access;

    // load address reads back the live counter
    always_comb begin
        rdata = '0;
        if (access) begin
            if (paddr[0] == ADDR_LOAD) begin
                rdata = count_q;
            end else if (paddr[0] == ADDR_CTRL) begin
                rdata = data_t'(ctrl_q);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            load_q  <= '0;
            count_q <= '0;
            ctrl_q  <= '0;
        end else if (write_en) begin
            if (paddr[0] == ADDR_LOAD) begin
                // a load write also restarts the count
                load_q  <= pwdata;
                count_q <= pwdata;
            end else if (paddr[0] == ADDR_CTRL) begin
                ctrl_q <= pwdata[1:0];
            end
        end else if (ctrl_q[CTRL_START]) begin
            // auto-reload at zero gives a period of load + 1
            if (count_q == '0) begin
                count_q <= load_q;
            end else begin
                count_q <= count_q - 1'b1;
            end
        end else if (ctrl_q[CTRL_RELOAD]) begin
            count_q <= load_q;
        end
    end

    // irq level is high for the one cycle the running counter sits at zero
    assign irq = ctrl_q[CTRL_START] && (count_q == '0);

endmodule

`default_nettype wire

// File: src/excl_monitor.sv
// exclusive access monitor, one owner entry per memory word
// entry 0 is unlocked, otherwise it holds the owning core ID plus one
`default_nettype none

module excl_monitor import periph_pkg::*; #(
    parameter int MEM_DEPTH = 64
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire logic [$clog2(MEM_DEPTH)-1:0]   word_addr,
    input  wire core_id_t                       core_id,
    input  wire                                 lwex,
    input  wire                                 swex,
    input  wire                                 commit,
    output logic                                swex_ok
);

    // one extra bit so that zero can mean unlocked
    typedef logic [CORE_ID_BITS:0] owner_t;

    owner_t owner_q [MEM_DEPTH];
    owner_t owner_rd;
    owner_t own_tag;
    logic   locked;
    logic   held_by_core;

    // table lookup is combinational so the decision is ready
    // in the same access cycle
    assign owner_rd     = owner_q[word_addr];
    assign own_tag      = owner_t'(core_id) + owner_t'(1);
    assign locked       = (owner_rd != '0);
    assign held_by_core = locked && (owner_rd == own_tag);

    // a SWEX only succeeds on a word this core locked itself
    assign swex_ok = swex && held_by_core;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                owner_q[i] <= '0;
            end
        end else if (commit) begin
            if (lwex && !locked) begin
                // first LWEX claims the word, later ones leave it alone
                owner_q[word_addr] <= own_tag;
            end else if (swex_ok) begin
                owner_q[word_addr] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/shared_bram.sv
// single-port word memory with a registered read
// read data follows the address one clock later, contents undefined at reset
`default_nettype none

module shared_bram import periph_pkg::*; #(
    parameter int MEM_DEPTH = 64
) (
    input  wire                                 clk,
    input  wire logic [$clog2(MEM_DEPTH)-1:0]   addr,
    input  wire data_t                          wdata,
    input  wire                                 we,
    output data_t                               rdata
);

    data_t mem [MEM_DEPTH];

    // read-before-write on a same-address collision
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: src/shared_mem_ex.sv
// APB shared memory with LWEX/SWEX support, no wait states
// LWEX counts only on reads and SWEX only on writes
`default_nettype none

module shared_mem_ex import periph_pkg::*; #(
    parameter int MEM_DEPTH = 64
) (
    input  wire            clk,
    input  wire            reset,
    input  wire apb_addr_t paddr,
    input  wire            pwrite,
    input  wire            sel,
    input  wire            penable,
    input  wire data_t     pwdata,
    output data_t          rdata,
    output logic           ready
);

    localparam int WORD_BITS = $clog2(MEM_DEPTH);

    logic                 access;
    logic                 commit;
    logic                 lwex;
    logic                 swex;
    core_id_t             core_id;
    logic [WORD_BITS-1:0] word_addr;
    logic                 swex_ok;
    logic                 mem_we;
    data_t                mem_rdata;

    // address fields
    assign lwex      = paddr[ADDR_LWEX_BIT] && !pwrite;
    assign swex      = paddr[ADDR_SWEX_BIT] && pwrite;
    assign core_id   = paddr[ADDR_CORE_LSB +: CORE_ID_BITS];
    assign word_addr = paddr[WORD_BITS-1:0];

    // memory word is registered on the setup edge, so the
    // first access cycle can already complete
    assign access = sel && penable;
    assign ready  = access;
    assign commit = access && ready;

    // plain writes always land, a SWEX only when it wins
    assign mem_we = commit && pwrite && (!swex || swex_ok);

    always_comb begin
        rdata = '0;
        if (access) begin
            if (swex) begin
                rdata = swex_ok ? SWEX_SUCCESS : SWEX_FAIL;
            end else begin
                rdata = mem_rdata;
            end
        end
    end

    excl_monitor #(
        .MEM_DEPTH (MEM_DEPTH)
    ) mon0 (
        .clk       (clk),
        .reset     (reset),
        .word_addr (word_addr),
        .core_id   (core_id),
        .lwex      (lwex),
        .swex      (swex),
        .commit    (commit),
        .swex_ok   (swex_ok)
    );

    shared_bram #(
        .MEM_DEPTH (MEM_DEPTH)
    ) mem0 (
        .clk   (clk),
        .addr  (word_addr),
        .wdata (pwdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: src/periph_top.sv
// APB peripheral block: decoder, countdown timer and exclusive shared memory
// single external master; core ID for exclusive accesses comes in paddr
`default_nettype none

module periph_top import periph_pkg::*; #(
    parameter int MEM_DEPTH = 64
) (
    input  wire            clk,
    input  wire            reset,
    input  wire apb_addr_t paddr,
    input  wire            pwrite,
    input  wire            psel,
    input  wire            penable,
    input  wire data_t     pwdata,
    output data_t          prdata,
    output logic           pready,
    output logic           timer_irq
);

    logic  timer_sel;
    logic  shmem_sel;
    data_t timer_rdata;
    logic  timer_ready;
    data_t shmem_rdata;
    logic  shmem_ready;

    apb_slave_decode decode0 (
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .timer_sel   (timer_sel),
        .shmem_sel   (shmem_sel),
        .timer_rdata (timer_rdata),
        .timer_ready (timer_ready),
        .shmem_rdata (shmem_rdata),
        .shmem_ready (shmem_ready),
        .prdata      (prdata),
        .pready      (pready)
    );

    apb_timer timer0 (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .pwrite  (pwrite),
        .sel     (timer_sel),
        .penable (penable),
        .pwdata  (pwdata),
        .rdata   (timer_rdata),
        .ready   (timer_ready),
        .irq     (timer_irq)
    );

    // exclusive monitor and memory share the same depth
    shared_mem_ex #(
        .MEM_DEPTH (MEM_DEPTH)
    ) shmem0 (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .pwrite  (pwrite),
        .sel     (shmem_sel),
        .penable (penable),
        .pwdata  (pwdata),
        .rdata   (shmem_rdata),
        .ready   (shmem_ready)
    );

endmodule

`default_nettype wire

// File: dv/tb_periph_top.sv
// testbench for periph_top that plays every core on the single APB port
// core ID and LWEX/SWEX flags are packed into paddr by the tests
`default_nettype none

module tb_periph_top;
    timeunit 1ns;
    timeprecision 1ps;

    // run limit at roughly ten times the length of all tests
    localparam int CYCLE_LIMIT  = 3000;
    localparam int ACCESS_LIMIT = 8;
    localparam int IRQ_PERIODS  = 4;

    localparam logic [19:0] TIMER_LOAD = 20'h00000;
    localparam logic [19:0] TIMER_CTRL = 20'h00001;
    localparam logic [15:0] SWEX_OK    = 16'h0000;
    localparam logic [15:0] SWEX_BAD   = 16'h0001;

    logic        clk;
    logic        reset;
    logic [19:0] paddr;
    logic        pwrite;
    logic        psel;
    logic        penable;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;
    logic        timer_irq;

    int          cycle_count;
    int          test_errors;
    int          pass_count;
    int          fail_count;
    logic [15:0] mem_model [64];
    logic [5:0]  probe_word;

    periph_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .paddr     (paddr),
        .pwrite    (pwrite),
        .psel      (psel),
        .penable   (penable),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .timer_irq (timer_irq)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic expect_data(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic expect_count(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
            test_errors++;
        end
    endtask

    // {lwex, swex, core, slave 1, zero, word}
    function automatic logic [19:0] mem_addr(input logic [1:0] core, input logic lwex,
                                             input logic swex, input logic [5:0] word);
        mem_addr = {lwex, swex, core, 4'h1, 6'h00, word};
    endfunction

    // setup cycle, then access cycles until pready; called at posedge + 2 ns
    task automatic transfer(input logic [19:0] addr, input logic is_write,
                            input logic [15:0] wdata, output logic [15:0] rdata);
        logic done;
        int   cycles;
        done    = 1'b0;
        cycles  = 0;
        rdata   = '0;
        paddr   = addr;
        pwrite  = is_write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        expect_count("pready in setup", 0, int'(pready));
        expect_data("prdata in setup", 16'h0000, prdata);
        @(posedge clk);
        #2;
        penable = 1'b1;
        while (!done && cycles < ACCESS_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (pready) begin
                rdata = prdata;
                done  = 1'b1;
            end
            @(posedge clk);
            #2;
        end
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        assert (done) else begin
            $display("transfer to 0x%h never completed", addr);
            test_errors++;
        end
        if (done) begin
            // no slave inserts wait states
            expect_count("access cycles", 1, cycles);
        end
    endtask

    task automatic write_data(input logic [19:0] addr, input logic [15:0] data);
        logic [15:0] unused_rd;
        transfer(addr, 1'b1, data, unused_rd);
    endtask

    task automatic read_data(input logic [19:0] addr, output logic [15:0] data);
        transfer(addr, 1'b0, 16'h0000, data);
    endtask

    task automatic load_excl(input logic [1:0] core, input logic [5:0] word,
                             output logic [15:0] data);
        transfer(mem_addr(core, 1'b1, 1'b0, word), 1'b0, 16'h0000, data);
    endtask

    task automatic store_excl(input logic [1:0] core, input logic [5:0] word,
                              input logic [15:0] data, output logic [15:0] status);
        transfer(mem_addr(core, 1'b0, 1'b1, word), 1'b1, data, status);
    endtask

    task automatic plain_write(input logic [1:0] core, input logic [5:0] word,
                               input logic [15:0] data);
        write_data(mem_addr(core, 1'b0, 1'b0, word), data);
        mem_model[word] = data;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic timer_registers();
        logic [15:0] load_val;
        logic [15:0] rd;
        // keep the load well above zero so a short run cannot wrap back to it
        load_val = 16'($urandom) | 16'h0100;
        // reset leaves the counter and control at zero
        expect_count("timer_irq after reset", 0, int'(timer_irq));
        read_data(TIMER_LOAD, rd);
        expect_data("timer count after reset", 16'h0000, rd);
        write_data(TIMER_LOAD, load_val);
        read_data(TIMER_LOAD, rd);
        expect_data("timer load", load_val, rd);
        // let the counter move off the load value before reload takes over
        write_data(TIMER_CTRL, 16'h0001);
        idle(2);
        write_data(TIMER_CTRL, 16'h0002);
        read_data(TIMER_CTRL, rd);
        expect_data("timer ctrl", 16'h0002, rd);
        // reload alone parks the counter on the load value
        repeat (3) begin
            idle(2);
            read_data(TIMER_LOAD, rd);
            expect_data("timer count with reload", load_val, rd);
        end
        end_test("timer registers");
    endtask

    task automatic timer_period();
        int   n;
        int   rises;
        int   last_rise;
        int   cyc;
        logic prev;
        n         = int'($urandom_range(10, 3));
        rises     = 0;
        last_rise = -1;
        cyc       = 0;
        prev      = 1'b0;
        write_data(TIMER_LOAD, 16'(n));
        write_data(TIMER_CTRL, 16'h0001);
        while (rises <= IRQ_PERIODS && cyc < (IRQ_PERIODS + 2) * (n + 1)) begin
            @(negedge clk);
            if (timer_irq && !prev) begin
                if (last_rise >= 0) begin
                    expect_count("timer_irq period", n + 1, cyc - last_rise);
                end
                last_rise = cyc;
                rises++;
            end
            assert (!(timer_irq && prev)) else begin
                $display("timer_irq stayed high for more than one cycle");
                test_errors++;
            end
            prev = timer_irq;
            cyc++;
        end
        @(posedge clk);
        #2;
        assert (rises > IRQ_PERIODS) else begin
            $display("timer_irq rose only %0d times while the timer ran", rises);
            test_errors++;
        end
        // stop while the counter sits at zero so only start can keep irq low
        idle(n - 1);
        write_data(TIMER_CTRL, 16'h0000);
        @(negedge clk);
        expect_count("timer_irq after stop", 0, int'(timer_irq));
        @(posedge clk);
        #2;
        end_test("timer period");
    endtask

    task automatic memory_plain();
        logic [5:0]  words [$];
        logic [5:0]  w;
        logic [15:0] rd;
        for (int i = 0; i < 6; i++) begin
            w = 6'($urandom);
            plain_write(2'(i), w, 16'($urandom));
            words.push_back(w);
        end
        foreach (words[i]) begin
            read_data(mem_addr(2'd0, 1'b0, 1'b0, words[i]), rd);
            expect_data("shmem word", mem_model[words[i]], rd);
        end
        end_test("memory plain access");
    endtask

    task automatic exclusive_conflict();
        logic [5:0]  w;
        logic [15:0] first;
        logic [15:0] second;
        logic [15:0] rd;
        w      = 6'($urandom);
        first  = 16'($urandom);
        second = ~first;
        plain_write(2'd0, w, first);
        load_excl(2'd1, w, rd);
        expect_data("lwex data", first, rd);
        store_excl(2'd2, w, second, rd);
        expect_data("swex status core 2", SWEX_BAD, rd);
        read_data(mem_addr(2'd0, 1'b0, 1'b0, w), rd);
        expect_data("shmem word after failed swex", first, rd);
        store_excl(2'd1, w, second, rd);
        expect_data("swex status core 1", SWEX_OK, rd);
        mem_model[w] = second;
        read_data(mem_addr(2'd0, 1'b0, 1'b0, w), rd);
        expect_data("shmem word after swex", second, rd);
        // the lock went away with the successful store
        store_excl(2'd1, w, first, rd);
        expect_data("repeated swex status", SWEX_BAD, rd);
        read_data(mem_addr(2'd0, 1'b0, 1'b0, w), rd);
        expect_data("shmem word after repeated swex", second, rd);
        end_test("exclusive conflict");
    endtask

    task automatic lock_isolation();
        logic [5:0]  a;
        logic [5:0]  b;
        logic [15:0] d;
        logic [15:0] rd;
        a = 6'($urandom);
        b = a + 6'($urandom_range(63, 1));
        plain_write(2'd0, a, 16'($urandom));
        plain_write(2'd0, b, 16'($urandom));
        load_excl(2'd0, a, rd);
        expect_data("lwex data word a", mem_model[a], rd);
        load_excl(2'd3, b, rd);
        expect_data("lwex data word b", mem_model[b], rd);
        d = 16'($urandom);
        store_excl(2'd3, b, d, rd);
        expect_data("swex status core 3", SWEX_OK, rd);
        mem_model[b] = d;
        // a plain write by core 2 lands and leaves core 0's lock alone
        plain_write(2'd2, a, 16'($urandom));
        read_data(mem_addr(2'd0, 1'b0, 1'b0, a), rd);
        expect_data("word a after plain write", mem_model[a], rd);
        d = 16'($urandom);
        store_excl(2'd0, a, d, rd);
        expect_data("swex status core 0", SWEX_OK, rd);
        mem_model[a] = d;
        read_data(mem_addr(2'd0, 1'b0, 1'b0, a), rd);
        expect_data("word a after swex", d, rd);
        read_data(mem_addr(2'd0, 1'b0, 1'b0, b), rd);
        expect_data("word b after swex", mem_model[b], rd);
        probe_word = a;
        end_test("lock isolation");
    endtask

    task automatic unmapped_slave();
        logic [19:0] addr;
        logic [15:0] count_before;
        logic [15:0] rd;
        // low address bits point at the probe word in case the write leaks into memory
        addr = {4'h0, 4'h5, 6'($urandom), probe_word};
        read_data(TIMER_LOAD, count_before);
        write_data(addr, ~mem_model[probe_word]);
        read_data(addr, rd);
        expect_data("unmapped prdata", 16'h0000, rd);
        read_data(TIMER_LOAD, rd);
        expect_data("timer count", count_before, rd);
        read_data(TIMER_CTRL, rd);
        expect_data("timer ctrl", 16'h0000, rd);
        read_data(mem_addr(2'd0, 1'b0, 1'b0, probe_word), rd);
        expect_data("shmem word", mem_model[probe_word], rd);
        end_test("unmapped slave");
    endtask

    initial begin
        void'($urandom(32'h3312));
        clk         = 1'b0;
        reset       = 1'b1;
        paddr       = '0;
        pwrite      = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwdata      = '0;
        cycle_count = 0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        probe_word  = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        timer_registers();
        timer_period();
        memory_plain();
        exclusive_conflict();
        lock_isolation();
        unmapped_slave();

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
src/periph_pkg.sv
src/apb_slave_decode.sv
src/apb_timer.sv
src/excl_monitor.sv
src/shared_bram.sv
src/shared_mem_ex.sv
src/periph_top.sv
dv/tb_periph_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the APB peripheral testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_periph_top \
    --Mdir "$BUILD_DIR" -o sim_periph \
    -f flist.f

"./$BUILD_DIR/sim_periph" | tee "$LOG_FILE"

if grep -qx "RESULT: PASS" "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG_FILE"
    exit 1
fi
